//--- source/audio_pkg.sv
package audio_pkg;

    //////////////////////////////
    // Sample format
    //////////////////////////////

    localparam int SAMPLE_WIDTH = 24;

    // Two's complement PCM word
    typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;

    // One channel with its one-cycle strobe
    typedef struct packed {
        logic    valid;
        sample_t data;
    } channel_sample_t;

    // Stream type between all blocks
    typedef struct packed {
        channel_sample_t left;
        channel_sample_t right;
    } stereo_sample_t;

    //////////////////////////////
    // Tone source
    //////////////////////////////

    localparam int TONE_LEN = 32;

    // One sine period at amplitude 2^22
    localparam sample_t TONE_TABLE [TONE_LEN] = '{
              0,   818268,  1605091,  2330230,
        2965821,  3487436,  3875032,  4113712,
        4194304,  4113712,  3875032,  3487436,
        2965821,  2330230,  1605091,   818268,
              0,  -818268, -1605091, -2330230,
       -2965821, -3487436, -3875032, -4113712,
       -4194304, -4113712, -3875032, -3487436,
       -2965821, -2330230, -1605091,  -818268
    };

    // Mean of two samples, rounds toward minus infinity
    function automatic sample_t sample_average(input sample_t a, input sample_t b);
        logic signed [SAMPLE_WIDTH:0] sum;
        sum = {a[SAMPLE_WIDTH-1], a} + {b[SAMPLE_WIDTH-1], b};
        return sum[SAMPLE_WIDTH:1];
    endfunction

endpackage

//--- source/ctrl_pkg.sv
package ctrl_pkg;

    //////////////////////////////
    // Playback source select
    //////////////////////////////

    typedef enum logic [1:0] {
        SRC_RX     = 2'd0,
        SRC_INTERP = 2'd1,
        SRC_TONE   = 2'd2,
        SRC_MUTE   = 2'd3
    } source_t;

    //////////////////////////////
    // I2S framing
    //////////////////////////////

    // Bit clocks per channel slot
    localparam int SLOT_BITS = 32;

endpackage

//--- source/i2s_rx.sv
`timescale 1ns/1ps

module i2s_rx (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      bclk,
    input  logic                      lrclk,
    input  logic                      sdata,
    output audio_pkg::stereo_sample_t stream
);
    import audio_pkg::*;
    import ctrl_pkg::*;

    localparam int CNT_W = $clog2(SLOT_BITS);

    // Pins sampled in the clk domain
    logic bclk_r;
    logic bclk_prev;
    logic lrclk_r;
    logic sdata_r;

    logic             lrclk_last;
    logic [CNT_W-1:0] bit_cnt;
    logic [CNT_W-1:0] bit_pos;
    logic             bclk_rise;
    logic             word_done;
    sample_t          shift;
    sample_t          word;

    logic    left_valid;
    logic    right_valid;
    sample_t left_data;
    sample_t right_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            bclk_r    <= 1'b0;
            bclk_prev <= 1'b0;
        end else begin
            bclk_r    <= bclk;
            bclk_prev <= bclk_r;
        end
    end

    always_ff @(posedge clk) begin
        lrclk_r <= lrclk;
        sdata_r <= sdata;
    end

    assign bclk_rise = bclk_r && !bclk_prev;

    // Position 0 is the delay bit right after an lrclk edge
    assign bit_pos = (lrclk_r != lrclk_last) ? '0 :
                     (bit_cnt == CNT_W'(SLOT_BITS - 1)) ? bit_cnt : bit_cnt + 1'b1;

    assign word      = {shift[SAMPLE_WIDTH-2:0], sdata_r};
    assign word_done = bclk_rise && (bit_pos == CNT_W'(SAMPLE_WIDTH));

    // Starts high so a first left slot counts as an edge
    always_ff @(posedge clk) begin
        if (reset) begin
            lrclk_last <= 1'b1;
            bit_cnt    <= CNT_W'(SLOT_BITS - 1);
        end else if (bclk_rise) begin
            lrclk_last <= lrclk_r;
            bit_cnt    <= bit_pos;
        end
    end

    // Only the last 24 bits shifted in matter
    always_ff @(posedge clk) begin
        if (bclk_rise) begin
            shift <= word;
        end
    end

    //////////////////////////////
    // Channel strobes
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            left_valid  <= 1'b0;
            right_valid <= 1'b0;
        end else begin
            left_valid  <= word_done && !lrclk_r;
            right_valid <= word_done && lrclk_r;
        end
    end

    always_ff @(posedge clk) begin
        if (word_done && !lrclk_r) begin
            left_data <= word;
        end
        if (word_done && lrclk_r) begin
            right_data <= word;
        end
    end

    assign stream.left  = '{valid: left_valid, data: left_data};
    assign stream.right = '{valid: right_valid, data: right_data};

endmodule

//--- source/interpolator.sv
`timescale 1ns/1ps

module interpolator #(
    parameter int INTERP_GAP = 8
) (
    input  logic                      clk,
    input  logic                      reset,
    input  audio_pkg::stereo_sample_t in_stream,
    output audio_pkg::stereo_sample_t out_stream
);
    import audio_pkg::*;

    localparam int GAP_W = $clog2(INTERP_GAP + 1);

    // Index 0 is left, index 1 is right
    channel_sample_t  in_ch     [2];
    logic             out_valid [2];
    sample_t          out_data  [2];
    sample_t          prev      [2];
    sample_t          pending   [2];
    logic [GAP_W-1:0] gap_cnt   [2];

    assign in_ch[0] = in_stream.left;
    assign in_ch[1] = in_stream.right;

    // Midpoint goes out first, new sample when the counter reaches 1
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int ch = 0; ch < 2; ch++) begin
                out_valid[ch] <= 1'b0;
                prev[ch]      <= '0;
                gap_cnt[ch]   <= '0;
            end
        end else begin
            for (int ch = 0; ch < 2; ch++) begin
                if (in_ch[ch].valid) begin
                    out_valid[ch] <= 1'b1;
                    gap_cnt[ch]   <= GAP_W'(INTERP_GAP - 1);
                end else if (gap_cnt[ch] == GAP_W'(1)) begin
                    out_valid[ch] <= 1'b1;
                    prev[ch]      <= pending[ch];
                    gap_cnt[ch]   <= '0;
                end else begin
                    out_valid[ch] <= 1'b0;
                    if (gap_cnt[ch] != '0) begin
                        gap_cnt[ch] <= gap_cnt[ch] - 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int ch = 0; ch < 2; ch++) begin
            if (in_ch[ch].valid) begin
                out_data[ch] <= sample_average(prev[ch], in_ch[ch].data);
                pending[ch]  <= in_ch[ch].data;
            end else if (gap_cnt[ch] == GAP_W'(1)) begin
                out_data[ch] <= pending[ch];
            end
        end
    end

    assign out_stream.left  = '{valid: out_valid[0], data: out_data[0]};
    assign out_stream.right = '{valid: out_valid[1], data: out_data[1]};

endmodule

//--- source/tone_gen.sv
`timescale 1ns/1ps

module tone_gen #(
    parameter int TONE_STEP = 3
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       run,
    input  logic                       frame_start,
    output audio_pkg::channel_sample_t tone
);
    import audio_pkg::*;

    localparam int IDX_W = $clog2(TONE_LEN);

    logic [IDX_W-1:0] phase;
    logic [IDX_W-1:0] phase_next;
    logic             tone_valid;
    sample_t          tone_data;

    // Wraps around the table
    assign phase_next = IDX_W'((int'(phase) + TONE_STEP) % TONE_LEN);

    // Phase parks at 0 while stopped
    always_ff @(posedge clk) begin
        if (reset || !run) begin
            phase      <= '0;
            tone_valid <= 1'b0;
        end else begin
            tone_valid <= frame_start;
            if (frame_start) begin
                phase <= phase_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (frame_start) begin
            tone_data <= TONE_TABLE[phase];
        end
    end

    assign tone = '{valid: tone_valid, data: tone_data};

endmodule

//--- source/source_mux.sv
`timescale 1ns/1ps

module source_mux (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       run,
    input  ctrl_pkg::source_t          select,
    input  audio_pkg::stereo_sample_t  rx,
    input  audio_pkg::stereo_sample_t  interp,
    input  audio_pkg::channel_sample_t tone,
    output audio_pkg::stereo_sample_t  pcm
);
    import audio_pkg::*;
    import ctrl_pkg::*;

    stereo_sample_t chosen;

    //////////////////////////////
    // Source pick
    //////////////////////////////

    always_comb begin
        case (select)
            SRC_RX:     chosen = rx;
            SRC_INTERP: chosen = interp;
            // Mono tone on both channels
            SRC_TONE:   chosen = '{left: tone, right: tone};
            SRC_MUTE: begin
                // Keep the receiver's pacing, silence the data
                chosen.left  = '{valid: rx.left.valid, data: '0};
                chosen.right = '{valid: rx.right.valid, data: '0};
            end
            default:    chosen = '0;
        endcase
    end

    //////////////////////////////
    // Output register
    //////////////////////////////

    // Each channel keeps its word until its own strobe
    always_ff @(posedge clk) begin
        if (reset || !run) begin
            pcm <= '0;
        end else begin
            pcm.left.valid  <= chosen.left.valid;
            pcm.right.valid <= chosen.right.valid;
            if (chosen.left.valid) begin
                pcm.left.data <= chosen.left.data;
            end
            if (chosen.right.valid) begin
                pcm.right.data <= chosen.right.data;
            end
        end
    end

endmodule

//--- source/i2s_tx.sv
`timescale 1ns/1ps

module i2s_tx #(
    parameter int BCLK_DIV = 4
) (
    input  logic                      clk,
    input  logic                      reset,
    input  audio_pkg::stereo_sample_t pcm,
    output logic                      frame_start,
    output logic                      bclk,
    output logic                      lrclk,
    output logic                      sdata
);
    import audio_pkg::*;
    import ctrl_pkg::*;

    localparam int FRAME_BITS = 2 * SLOT_BITS;
    localparam int CNT_W      = $clog2(FRAME_BITS);
    localparam int DIV_W      = $clog2(BCLK_DIV + 1);
    localparam int PAD_BITS   = SLOT_BITS - SAMPLE_WIDTH;

    logic [DIV_W-1:0]     div_cnt;
    logic                 div_tick;
    logic                 bclk_fall;
    logic [CNT_W-1:0]     bit_cnt;
    logic [CNT_W-1:0]     next_bit;
    sample_t              held_l;
    sample_t              held_r;
    sample_t              frame_r;
    logic [SLOT_BITS-1:0] shift;

    assign div_tick  = (div_cnt == DIV_W'(BCLK_DIV - 1));
    assign bclk_fall = div_tick && bclk;
    assign next_bit  = (bit_cnt == CNT_W'(FRAME_BITS - 1)) ? '0 : bit_cnt + 1'b1;

    // Latest words from the mux
    always_ff @(posedge clk) begin
        if (reset) begin
            held_l <= '0;
            held_r <= '0;
        end else begin
            if (pcm.left.valid) begin
                held_l <= pcm.left.data;
            end
            if (pcm.right.valid) begin
                held_r <= pcm.right.data;
            end
        end
    end

    //////////////////////////////
    // Bit clock and framing
    //////////////////////////////

    // First falling edge after reset opens a left slot
    always_ff @(posedge clk) begin
        if (reset) begin
            div_cnt     <= '0;
            bclk        <= 1'b0;
            lrclk       <= 1'b0;
            sdata       <= 1'b0;
            bit_cnt     <= CNT_W'(FRAME_BITS - 1);
            frame_start <= 1'b0;
        end else begin
            div_cnt     <= div_tick ? '0 : div_cnt + 1'b1;
            frame_start <= 1'b0;
            if (div_tick) begin
                bclk <= ~bclk;
            end
            if (bclk_fall) begin
                bit_cnt <= next_bit;
                lrclk   <= (next_bit >= CNT_W'(SLOT_BITS));
                // Delay bit is the zero that opens every slot
                if (next_bit == '0 || next_bit == CNT_W'(SLOT_BITS)) begin
                    sdata <= 1'b0;
                end else begin
                    sdata <= shift[SLOT_BITS-1];
                end
                frame_start <= (next_bit == '0);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bclk_fall) begin
            if (next_bit == '0) begin
                shift   <= {held_l, {PAD_BITS{1'b0}}};
                frame_r <= held_r;
            end else if (next_bit == CNT_W'(SLOT_BITS)) begin
                shift <= {frame_r, {PAD_BITS{1'b0}}};
            end else begin
                shift <= shift << 1;
            end
        end
    end

endmodule

//--- source/audio_path.sv
`timescale 1ns/1ps

module audio_path #(
    parameter int BCLK_DIV   = 4,
    parameter int TONE_STEP  = 3,
    parameter int INTERP_GAP = 8
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      run,
    input  ctrl_pkg::source_t         select,
    input  logic                      rx_bclk,
    input  logic                      rx_lrclk,
    input  logic                      rx_sdata,
    output logic                      tx_bclk,
    output logic                      tx_lrclk,
    output logic                      tx_sdata,
    output audio_pkg::stereo_sample_t pcm
);
    import audio_pkg::*;

    stereo_sample_t  rx_stream;
    stereo_sample_t  interp_stream;
    channel_sample_t tone_word;
    logic            frame_start;

    //////////////////////////////
    // Sources
    //////////////////////////////

    i2s_rx rx0 (
        .clk    (clk),
        .reset  (reset),
        .bclk   (rx_bclk),
        .lrclk  (rx_lrclk),
        .sdata  (rx_sdata),
        .stream (rx_stream)
    );

    interpolator #(
        .INTERP_GAP (INTERP_GAP)
    ) interp0 (
        .clk        (clk),
        .reset      (reset),
        .in_stream  (rx_stream),
        .out_stream (interp_stream)
    );

    // Paced by the transmitter frames
    tone_gen #(
        .TONE_STEP (TONE_STEP)
    ) tone0 (
        .clk         (clk),
        .reset       (reset),
        .run         (run),
        .frame_start (frame_start),
        .tone        (tone_word)
    );

    //////////////////////////////
    // Selection and playback
    //////////////////////////////

    source_mux mux0 (
        .clk    (clk),
        .reset  (reset),
        .run    (run),
        .select (select),
        .rx     (rx_stream),
        .interp (interp_stream),
        .tone   (tone_word),
        .pcm    (pcm)
    );

    i2s_tx #(
        .BCLK_DIV (BCLK_DIV)
    ) tx0 (
        .clk         (clk),
        .reset       (reset),
        .pcm         (pcm),
        .frame_start (frame_start),
        .bclk        (tx_bclk),
        .lrclk       (tx_lrclk),
        .sdata       (tx_sdata)
    );

endmodule

//--- bench/audio_path_checker.sv
`timescale 1ns/1ps

module audio_path_checker #(
    parameter int INTERP_GAP = 8
) (
    input logic                      clk,
    input logic                      reset,
    input logic                      run,
    input audio_pkg::stereo_sample_t pcm,
    input audio_pkg::stereo_sample_t rx_stream,
    input logic                      tx_bclk,
    input logic                      tx_lrclk,
    input logic                      frame_start
);
    import audio_pkg::*;

    // Read by the testbench at the end of the run
    int unsigned fail_count = 0;

    //////////////////////////////
    // Playback output
    //////////////////////////////

    // Mux output register clears one cycle after run drops
    pcm_silent_when_stopped: assert property (@(posedge clk) disable iff (reset)
        !run |=> !pcm.left.valid && !pcm.right.valid)
    else begin
        $error("pcm strobe while run is low");
        fail_count++;
    end

    lrclk_moves_on_bclk_fall: assert property (@(posedge clk) disable iff (reset)
        $changed(tx_lrclk) |-> $fell(tx_bclk))
    else begin
        $error("tx_lrclk changed away from a falling tx_bclk");
        fail_count++;
    end

    frame_start_single_cycle: assert property (@(posedge clk) disable iff (reset)
        frame_start |=> !frame_start)
    else begin
        $error("frame_start longer than one cycle");
        fail_count++;
    end

    //////////////////////////////
    // Interpolator input pacing
    //////////////////////////////

    left_strobe_spacing: assert property (@(posedge clk) disable iff (reset)
        rx_stream.left.valid |=> !rx_stream.left.valid [*INTERP_GAP])
    else begin
        $error("left interpolator inputs too close together");
        fail_count++;
    end

    right_strobe_spacing: assert property (@(posedge clk) disable iff (reset)
        rx_stream.right.valid |=> !rx_stream.right.valid [*INTERP_GAP])
    else begin
        $error("right interpolator inputs too close together");
        fail_count++;
    end

endmodule

//--- bench/audio_path_tb.sv
`timescale 1ns/1ps

module audio_path_tb;
    import audio_pkg::*;
    import ctrl_pkg::*;

    localparam int BCLK_DIV    = 4;
    localparam int TONE_STEP   = 3;
    localparam int INTERP_GAP  = 8;
    localparam int CLK_NS      = 40;
    // Receive side bit clock is 8 clk per period
    localparam int HALF_BIT    = 4;
    localparam int BIT_NS      = 2 * BCLK_DIV * CLK_NS;
    localparam int FRAME_COUNT = 33;
    localparam int WATCHDOG_NS = FRAME_COUNT * 2 * SLOT_BITS * BIT_NS + 100000;

    logic           clk;
    logic           reset;
    logic           run;
    source_t        select;
    logic           rx_bclk;
    logic           rx_lrclk;
    logic           rx_sdata;
    logic           tx_bclk;
    logic           tx_lrclk;
    logic           tx_sdata;
    stereo_sample_t pcm;

    integer  seed = 76209;
    sample_t last_left;
    sample_t last_right;

    audio_path #(
        .BCLK_DIV   (BCLK_DIV),
        .TONE_STEP  (TONE_STEP),
        .INTERP_GAP (INTERP_GAP)
    ) dut0 (
        .clk      (clk),
        .reset    (reset),
        .run      (run),
        .select   (select),
        .rx_bclk  (rx_bclk),
        .rx_lrclk (rx_lrclk),
        .rx_sdata (rx_sdata),
        .tx_bclk  (tx_bclk),
        .tx_lrclk (tx_lrclk),
        .tx_sdata (tx_sdata),
        .pcm      (pcm)
    );

    bind audio_path audio_path_checker #(
        .INTERP_GAP (INTERP_GAP)
    ) chk0 (
        .clk         (clk),
        .reset       (reset),
        .run         (run),
        .pcm         (pcm),
        .rx_stream   (rx_stream),
        .tx_bclk     (tx_bclk),
        .tx_lrclk    (tx_lrclk),
        .frame_start (frame_start)
    );

    initial clk = 1'b0;
    always #(CLK_NS / 2) clk = ~clk;

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before all tests finished");
        $display("Errors found");
        $fatal(1, "Run stopped by watchdog");
    end

    // First checker assertion failure ends the run
    initial begin
        wait (dut0.chk0.fail_count != 0);
        $display("A checker assertion failed");
        stop_on_failure();
    end

    //////////////////////////////
    // Helpers
    //////////////////////////////

    task automatic stop_on_failure();
        $display("Errors found");
        $fatal(1, "Stopping at the first failed check");
    endtask

    task automatic compare_channel(input channel_sample_t got, input channel_sample_t exp,
                                   input string name);
        if (got !== exp) begin
            $display("[ERROR] %0t ns %s: got valid=%b data=%0d, expected valid=%b data=%0d",
                     $time, name, got.valid, got.data, exp.valid, exp.data);
            stop_on_failure();
        end
    endtask

    task automatic compare_sample(input sample_t got, input sample_t exp, input string name);
        if (got !== exp) begin
            $display("[ERROR] %0t ns %s: got %0d, expected %0d", $time, name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic compare_bit(input logic got, input logic exp, input string name);
        if (got !== exp) begin
            $display("[ERROR] %0t ns %s: got %b, expected %b", $time, name, got, exp);
            stop_on_failure();
        end
    endtask

    // Mean of two samples, floor rounding
    function automatic sample_t midpoint(input sample_t a, input sample_t b);
        int sum;
        sum = int'(a) + int'(b);
        return sample_t'(sum >>> 1);
    endfunction

    function automatic sample_t random_sample();
        return sample_t'($random(seed));
    endfunction

    // Leaves the bench 2 ns after a rising edge
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #2;
    endtask

    task automatic set_mode(input logic run_level, input source_t sel);
        wait_cycles(1);
        run    = run_level;
        select = sel;
    endtask

    // One I2S frame on the rx pins, data changes with bclk low
    task automatic send_frame(input sample_t left, input sample_t right);
        logic [2*SLOT_BITS-1:0] bits;
        bits = {1'b0, left, 7'b0, 1'b0, right, 7'b0};
        for (int i = 0; i < 2 * SLOT_BITS; i++) begin
            rx_bclk  = 1'b0;
            rx_lrclk = (i >= SLOT_BITS);
            rx_sdata = bits[2*SLOT_BITS-1-i];
            wait_cycles(HALF_BIT);
            rx_bclk = 1'b1;
            wait_cycles(HALF_BIT);
        end
        last_left  = left;
        last_right = right;
    endtask

    // Next full frame on the tx pins, sampled on rising bclk
    task automatic decode_frame(output sample_t left, output sample_t right);
        left  = '0;
        right = '0;
        @(negedge tx_lrclk);
        for (int i = 0; i < 2 * SLOT_BITS; i++) begin
            @(posedge tx_bclk);
            if (i >= 1 && i <= SAMPLE_WIDTH) begin
                left = {left[SAMPLE_WIDTH-2:0], tx_sdata};
            end else if (i >= SLOT_BITS + 1 && i <= SLOT_BITS + SAMPLE_WIDTH) begin
                right = {right[SAMPLE_WIDTH-2:0], tx_sdata};
            end
        end
        wait_cycles(1);
    endtask

    // pcm must strobe exactly one cycle after the receiver strobe
    task automatic expect_follow(input logic is_right, input sample_t exp);
        channel_sample_t want;
        channel_sample_t got;
        want = '{valid: 1'b1, data: exp};
        do @(negedge clk);
        while (!(is_right ? dut0.rx_stream.right.valid : dut0.rx_stream.left.valid));
        @(negedge clk);
        got = is_right ? pcm.right : pcm.left;
        compare_channel(got, want, is_right ? "pcm.right" : "pcm.left");
    endtask

    task automatic expect_pcm(input logic is_right, input sample_t exp);
        channel_sample_t want;
        channel_sample_t got;
        want = '{valid: 1'b1, data: exp};
        do @(negedge clk);
        while (!(is_right ? pcm.right.valid : pcm.left.valid));
        got = is_right ? pcm.right : pcm.left;
        compare_channel(got, want, is_right ? "pcm.right" : "pcm.left");
    endtask

    //////////////////////////////
    // Directed tests
    //////////////////////////////

    task automatic test_run_low();
        sample_t l0;
        sample_t r0;
        sample_t l1;
        sample_t r1;
        logic    done;
        @(negedge clk);
        compare_bit(tx_bclk, 1'b0, "tx_bclk");
        compare_bit(tx_lrclk, 1'b0, "tx_lrclk");
        compare_bit(tx_sdata, 1'b0, "tx_sdata");
        wait_cycles(1);
        l0   = random_sample();
        r0   = random_sample();
        l1   = random_sample();
        r1   = random_sample();
        done = 1'b0;
        fork
            begin
                send_frame(l0, r0);
                send_frame(l1, r1);
                done = 1'b1;
            end
            while (!done) begin
                @(negedge clk);
                compare_channel(pcm.left, '0, "pcm.left");
                compare_channel(pcm.right, '0, "pcm.right");
            end
        join
    endtask

    task automatic test_passthrough();
        sample_t l;
        sample_t r;
        sample_t dl;
        sample_t dr;
        set_mode(1'b1, SRC_RX);
        repeat (3) begin
            l = random_sample();
            r = random_sample();
            fork
                send_frame(l, r);
                begin
                    expect_follow(1'b0, l);
                    expect_follow(1'b1, r);
                end
            join
            decode_frame(dl, dr);
            compare_sample(dl, l, "tx left");
            compare_sample(dr, r, "tx right");
        end
    endtask

    task automatic test_interpolation();
        sample_t l;
        sample_t r;
        sample_t mid_l;
        sample_t mid_r;
        set_mode(1'b1, SRC_INTERP);
        repeat (3) begin
            l     = random_sample();
            r     = random_sample();
            mid_l = midpoint(last_left, l);
            mid_r = midpoint(last_right, r);
            fork
                send_frame(l, r);
                begin
                    expect_pcm(1'b0, mid_l);
                    expect_pcm(1'b0, l);
                    expect_pcm(1'b1, mid_r);
                    expect_pcm(1'b1, r);
                end
            join
        end
    endtask

    task automatic test_tone();
        sample_t dl;
        sample_t dr;
        logic    found;
        int      idx;
        // Dropping run parks the phase at 0
        set_mode(1'b0, SRC_TONE);
        wait_cycles(2);
        set_mode(1'b1, SRC_TONE);
        found = 1'b0;
        for (int k = 0; k < 6 && !found; k++) begin
            decode_frame(dl, dr);
            found = (dl == TONE_TABLE[TONE_STEP]);
        end
        if (!found) begin
            $display("Tone output never reached table entry %0d", TONE_STEP);
            stop_on_failure();
        end
        compare_sample(dr, TONE_TABLE[TONE_STEP], "tx right");
        for (int k = 2; k < 6; k++) begin
            idx = (k * TONE_STEP) % TONE_LEN;
            decode_frame(dl, dr);
            compare_sample(dl, TONE_TABLE[idx], "tx left");
            compare_sample(dr, TONE_TABLE[idx], "tx right");
        end
    endtask

    task automatic test_mute();
        sample_t dl;
        sample_t dr;
        set_mode(1'b1, SRC_MUTE);
        repeat (2) begin
            fork
                send_frame(random_sample(), random_sample());
                begin
                    expect_follow(1'b0, '0);
                    expect_follow(1'b1, '0);
                end
            join
            decode_frame(dl, dr);
            compare_sample(dl, '0, "tx left");
            compare_sample(dr, '0, "tx right");
        end
    endtask

    // Same left word every frame, only the right word moves
    task automatic test_channel_hold();
        sample_t l;
        sample_t r;
        set_mode(1'b1, SRC_RX);
        l = random_sample();
        repeat (3) begin
            r = random_sample();
            fork
                send_frame(l, r);
                begin
                    expect_follow(1'b0, l);
                    expect_follow(1'b1, r);
                    compare_sample(pcm.left.data, l, "pcm.left.data");
                end
            join
        end
    endtask

    initial begin
        reset      = 1'b1;
        run        = 1'b0;
        select     = SRC_RX;
        rx_bclk    = 1'b0;
        rx_lrclk   = 1'b0;
        rx_sdata   = 1'b0;
        last_left  = '0;
        last_right = '0;
        wait_cycles(2);
        reset = 1'b0;

        test_run_low();
        test_passthrough();
        test_interpolation();
        test_tone();
        test_mute();
        test_channel_hold();

        wait_cycles(4);
        if (dut0.chk0.fail_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- project.f
source/audio_pkg.sv
source/ctrl_pkg.sv
source/i2s_rx.sv
source/interpolator.sv
source/tone_gen.sv
source/source_mux.sv
source/i2s_tx.sv
source/audio_path.sv
bench/audio_path_checker.sv
bench/audio_path_tb.sv

//--- Bender.yml
package:
  name: audio_path

sources:
  - files:
      - source/audio_pkg.sv
      - source/ctrl_pkg.sv
      - source/i2s_rx.sv
      - source/interpolator.sv
      - source/tone_gen.sv
      - source/source_mux.sv
      - source/i2s_tx.sv
      - source/audio_path.sv
  - target: test
    files:
      - bench/audio_path_checker.sv
      - bench/audio_path_tb.sv
